/* project.f */
source/ahb_apb_pkg.sv
source/ahb_front.sv
source/apb_addr_decode.sv
source/apb_master_fsm.sv
source/ahb_apb_bridge.sv
verification/apb_slave_model.sv
verification/tb_ahb_apb_bridge.sv

/* Bender.yml */
package:
  name: ahb_apb_bridge

sources:
  - files:
      - source/ahb_apb_pkg.sv
      - source/ahb_front.sv
      - source/apb_addr_decode.sv
      - source/apb_master_fsm.sv
      - source/ahb_apb_bridge.sv
  - target: simulation
    files:
      - verification/apb_slave_model.sv
      - verification/tb_ahb_apb_bridge.sv

/* verification/tb_ahb_apb_bridge.sv */
// Testbench for the AHB-to-APB bridge with a transfer table, APB monitor and checks
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_apb_bridge;

  import ahb_apb_pkg::*;

  localparam int    NUM_SLAVES  = 4;
  localparam int    N_TESTS     = 17;
  localparam int    CYCLE_LIMIT = N_TESTS * 12 + 50;
  localparam int    WAIT_TAB [NUM_SLAVES] = '{0, 1, 3, 0};
  localparam addr_t SLAVE_START [NUM_SLAVES] = '{32'h0000_0000, 32'h0000_1000,
                                                 32'h0001_0000, 32'h0002_0000};
  localparam addr_t SLAVE_END [NUM_SLAVES] = '{32'h0000_0FFF, 32'h0000_1FFF,
                                               32'h0001_00FF, 32'h0002_FFFF};

  logic                       hclk5 = 1'b0;
  logic                       hreset_n5;
  logic                       hsel;
  addr_t                      haddr;
  htrans_e                    htrans;
  logic                       hwrite;
  data_t                      hwdata;
  logic                       hready;
  data_t                      hrdata;
  addr_t                      paddr;
  logic                       pwrite;
  data_t                      pwdata;
  logic                       penable;
  logic [NUM_SLAVES-1:0]      psel;
  wire logic [NUM_SLAVES-1:0] pready;
  wire data_t                 prdata [NUM_SLAVES];

  // Transfer table, one row per test
  string   t_name [N_TESTS];
  logic    t_hsel [N_TESTS];
  htrans_e t_htrans [N_TESTS];
  logic    t_write [N_TESTS];
  addr_t   t_addr [N_TESTS];
  int      t_slave [N_TESTS];
  data_t   t_wdata [N_TESTS];
  int      n_entries;

  // Reference copy of every slave memory
  data_t                 shadow [NUM_SLAVES][16];
  int                    setup_cnt;
  logic                  any_psel;
  logic                  pen_next;
  logic                  pen_ok;
  logic [NUM_SLAVES-1:0] mon_psel;
  addr_t                 mon_paddr;
  logic                  mon_pwrite;
  data_t                 mon_pwdata;
  int                    cycles;
  int                    errors;
  int                    tests_ok;
  int                    tests_bad;
  logic                  test_bad;
  integer                seed;

  ahb_apb_bridge #(
    .NUM_SLAVES  (NUM_SLAVES),
    .SLAVE_START (SLAVE_START),
    .SLAVE_END   (SLAVE_END)
  ) UUT (
    .hclk5     (hclk5),
    .hreset_n5 (hreset_n5),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (hrdata),
    .paddr     (paddr),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .penable   (penable),
    .psel      (psel),
    .pready    (pready),
    .prdata    (prdata)
  );

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
    apb_slave_model #(
      .WAIT_STATES (WAIT_TAB[i])
    ) u_slave (
      .hclk5     (hclk5),
      .hreset_n5 (hreset_n5),
      .psel      (psel[i]),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .pready    (pready[i]),
      .prdata    (prdata[i])
    );
  end

  initial begin
    forever begin
      #2 hclk5 = ~hclk5;
    end
  end

  always @(posedge hclk5) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: no completion within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // APB monitor
  // ------------------------------------------------------------------------
  // SETUP is psel high with penable low
  always @(posedge hclk5) begin
    if (psel != '0) begin
      any_psel = 1'b1;
    end
    if ((psel != '0) && !penable) begin
      setup_cnt  = setup_cnt + 1;
      mon_psel   = psel;
      mon_paddr  = paddr;
      mon_pwrite = pwrite;
      pen_next   = 1'b1;
    end else if (pen_next) begin
      pen_ok     = penable && (psel == mon_psel);
      mon_pwdata = pwdata;
      pen_next   = 1'b0;
    end
  end

  task automatic add_entry(input string name, input logic hs, input htrans_e ht,
                           input logic wr, input addr_t addr, input int slave);
    t_name[n_entries]   = name;
    t_hsel[n_entries]   = hs;
    t_htrans[n_entries] = ht;
    t_write[n_entries]  = wr;
    t_addr[n_entries]   = addr;
    t_slave[n_entries]  = slave;
    t_wdata[n_entries]  = $random(seed);
    n_entries           = n_entries + 1;
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("ERR %s %s: expected %h, actual %h", name, field, exp_v, act_v);
    errors   = errors + 1;
    test_bad = 1'b1;
  endtask

  task automatic report_problem(input string name, input string what);
    $display("Test %s: %s", name, what);
    errors   = errors + 1;
    test_bad = 1'b1;
  endtask

  task automatic finish_test(input string name);
    if (test_bad) begin
      tests_bad = tests_bad + 1;
      $display("Test %s failed", name);
    end else begin
      tests_ok = tests_ok + 1;
      $display("Test %s ok", name);
    end
    test_bad = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // One address phase, then wait for hready and check the result
  // ------------------------------------------------------------------------
  task automatic run_entry(input int i);
    int                    lo;
    int                    exp_lo;
    int                    s;
    logic                  taken;
    logic [3:0]            idx;
    logic [NUM_SLAVES-1:0] exp_sel;
    data_t                 exp_rd;
    lo    = 0;
    s     = t_slave[i];
    idx   = t_addr[i][5:2];
    taken = t_hsel[i] && ((t_htrans[i] == HTRANS_NONSEQ) || (t_htrans[i] == HTRANS_SEQ));
    exp_sel = '0;
    exp_rd  = '0;
    exp_lo  = 0;
    if (s >= 0) begin
      exp_sel[s] = 1'b1;
      exp_rd     = shadow[s][idx];
    end
    if (taken) begin
      exp_lo = (s >= 0) ? 3 + WAIT_TAB[s] : 3;
    end
    @(negedge hclk5);
    setup_cnt = 0;
    any_psel  = 1'b0;
    pen_next  = 1'b0;
    pen_ok    = 1'b0;
    hsel      = t_hsel[i];
    htrans    = t_htrans[i];
    hwrite    = t_write[i];
    haddr     = t_addr[i];
    @(negedge hclk5);
    htrans = HTRANS_IDLE;
    hwdata = t_wdata[i];
    while (!hready) begin
      lo = lo + 1;
      @(negedge hclk5);
    end
    // Idle gap so a wrongly taken transfer still shows up on psel
    repeat (3) @(negedge hclk5);
    if (lo != exp_lo) begin
      report_mismatch(t_name[i], "hready low cycles", exp_lo, lo);
    end
    if (taken && !t_write[i] && (hrdata !== exp_rd)) begin
      report_mismatch(t_name[i], "hrdata", exp_rd, hrdata);
    end
    if (s >= 0) begin
      if (setup_cnt != 1) begin
        report_problem(t_name[i], "expected exactly one APB SETUP phase");
      end
      if (mon_psel !== exp_sel) begin
        report_mismatch(t_name[i], "psel", exp_sel, mon_psel);
      end
      if (mon_paddr !== t_addr[i]) begin
        report_mismatch(t_name[i], "paddr", t_addr[i], mon_paddr);
      end
      if (mon_pwrite !== t_write[i]) begin
        report_mismatch(t_name[i], "pwrite", t_write[i], mon_pwrite);
      end
      if (t_write[i] && (mon_pwdata !== t_wdata[i])) begin
        report_mismatch(t_name[i], "pwdata", t_wdata[i], mon_pwdata);
      end
      if (!pen_ok) begin
        report_problem(t_name[i], "penable did not rise one cycle after psel");
      end
    end else if (any_psel) begin
      report_problem(t_name[i], "psel raised although no slave should be selected");
    end
    if (taken && t_write[i] && (s >= 0)) begin
      shadow[s][idx] = t_wdata[i];
    end
    finish_test(t_name[i]);
  endtask

  initial begin
    hreset_n5  = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = HTRANS_IDLE;
    hwrite     = 1'b0;
    hwdata     = '0;
    cycles     = 0;
    errors     = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    test_bad   = 1'b0;
    n_entries  = 0;
    setup_cnt  = 0;
    any_psel   = 1'b0;
    pen_next   = 1'b0;
    pen_ok     = 1'b0;
    mon_psel   = '0;
    mon_paddr  = '0;
    mon_pwrite = 1'b0;
    mon_pwdata = '0;
    seed       = 32'hd492_2060;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      for (int w = 0; w < 16; w++) begin
        shadow[s][w] = '0;
      end
    end
    add_entry("wr_s0_mid", 1'b1, HTRANS_NONSEQ, 1'b1, 32'h0000_0010, 0);
    add_entry("wr_s1_top", 1'b1, HTRANS_NONSEQ, 1'b1, 32'h0000_1FFC, 1);
    add_entry("wr_s2_seq", 1'b1, HTRANS_SEQ, 1'b1, 32'h0001_0020, 2);
    add_entry("wr_s3_top", 1'b1, HTRANS_NONSEQ, 1'b1, 32'h0002_FFF0, 3);
    add_entry("wr_s0_base", 1'b1, HTRANS_NONSEQ, 1'b1, 32'h0000_0000, 0);
    add_entry("rd_s0_mid", 1'b1, HTRANS_NONSEQ, 1'b0, 32'h0000_0010, 0);
    add_entry("rd_s1_top", 1'b1, HTRANS_SEQ, 1'b0, 32'h0000_1FFC, 1);
    add_entry("rd_s2_seq", 1'b1, HTRANS_NONSEQ, 1'b0, 32'h0001_0020, 2);
    add_entry("rd_s3_top", 1'b1, HTRANS_NONSEQ, 1'b0, 32'h0002_FFF0, 3);
    add_entry("rd_s0_base", 1'b1, HTRANS_NONSEQ, 1'b0, 32'h0000_0000, 0);
    // Follows a nonzero read so a stale hrdata cannot pass as zero
    add_entry("rd_unmapped", 1'b1, HTRANS_NONSEQ, 1'b0, 32'h0003_0000, -1);
    add_entry("wr_unmapped", 1'b1, HTRANS_NONSEQ, 1'b1, 32'h0003_0000, -1);
    add_entry("rd_s2_fresh", 1'b1, HTRANS_NONSEQ, 1'b0, 32'h0001_0000, 2);
    add_entry("idle_trans", 1'b1, HTRANS_IDLE, 1'b1, 32'h0000_0010, -1);
    add_entry("busy_trans", 1'b1, HTRANS_BUSY, 1'b1, 32'h0000_1FFC, -1);
    add_entry("hsel_low", 1'b0, HTRANS_NONSEQ, 1'b1, 32'h0000_0010, -1);
    add_entry("rd_s0_again", 1'b1, HTRANS_NONSEQ, 1'b0, 32'h0000_0010, 0);
    repeat (5) @(negedge hclk5);
    hreset_n5 = 1'b1;
    @(negedge hclk5);
    if (hready !== 1'b1) begin
      report_mismatch("reset", "hready", 32'd1, hready);
    end
    if (psel !== '0) begin
      report_mismatch("reset", "psel", 32'd0, psel);
    end
    if (penable !== 1'b0) begin
      report_mismatch("reset", "penable", 32'd0, penable);
    end
    finish_test("reset");
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_ok, tests_bad, errors);
    if ((errors == 0) && (tests_bad == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/apb_slave_model.sv */
// APB slave memory model with programmable wait states
`timescale 1ns/1ps
`default_nettype none

module apb_slave_model #(
  parameter int WAIT_STATES = 0
) (
  input  wire logic               hclk5,
  input  wire logic               hreset_n5,
  input  wire logic               psel,
  input  wire logic               penable,
  input  wire logic               pwrite,
  input  wire ahb_apb_pkg::addr_t paddr,
  input  wire ahb_apb_pkg::data_t pwdata,
  output logic                    pready,
  output ahb_apb_pkg::data_t      prdata
);

  import ahb_apb_pkg::*;

  data_t mem [16];
  int    wait_cnt;
  logic  access;

  assign access = psel && penable;
  assign pready = access && (wait_cnt == WAIT_STATES);

  // Not gated by psel, the bridge mux has to mask it
  assign prdata = mem[paddr[5:2]];

  always_ff @(posedge hclk5 or negedge hreset_n5) begin
    if (!hreset_n5) begin
      wait_cnt <= 0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // Count ACCESS cycles until pready
      if (access && !pready) begin
        wait_cnt <= wait_cnt + 1;
      end else begin
        wait_cnt <= 0;
      end
      if (access && pready && pwrite) begin
        mem[paddr[5:2]] <= pwdata;
      end
    end
  end

endmodule

`default_nettype wire

/* source/ahb_apb_bridge.sv */
// AHB-to-APB bridge top level connecting front end, address decode and APB master
`timescale 1ns/1ps
`default_nettype none

module ahb_apb_bridge #(
  parameter int                 NUM_SLAVES = 4,
  parameter ahb_apb_pkg::addr_t SLAVE_START [NUM_SLAVES] = '{
    32'h0000_0000, 32'h0000_1000, 32'h0001_0000, 32'h0002_0000
  },
  parameter ahb_apb_pkg::addr_t SLAVE_END   [NUM_SLAVES] = '{
    32'h0000_0FFF, 32'h0000_1FFF, 32'h0001_00FF, 32'h0002_FFFF
  }
) (
  input  wire logic                   hclk5,
  input  wire logic                   hreset_n5,
  // AHB slave side
  input  wire logic                   hsel,
  input  wire ahb_apb_pkg::addr_t     haddr,
  input  wire ahb_apb_pkg::htrans_e   htrans,
  input  wire logic                   hwrite,
  input  wire ahb_apb_pkg::data_t     hwdata,
  output logic                        hready,
  output ahb_apb_pkg::data_t          hrdata,
  // APB master side
  output ahb_apb_pkg::addr_t          paddr,
  output logic                        pwrite,
  output ahb_apb_pkg::data_t          pwdata,
  output logic                        penable,
  output logic [NUM_SLAVES-1:0]       psel,
  input  wire logic [NUM_SLAVES-1:0]  pready,
  input  wire ahb_apb_pkg::data_t     prdata [NUM_SLAVES]
);

  import ahb_apb_pkg::*;

  logic                  accept;
  addr_t                 addr_q;
  logic                  write_q;
  logic                  data_phase;
  logic [NUM_SLAVES-1:0] sel_q;
  logic                  done;
  data_t                 rdata_mux;

  // Write data is valid during the AHB data phase, which spans SETUP and ACCESS
  assign pwdata = hwdata;

  ahb_front u_ahb_front (
    .hclk5      (hclk5),
    .hreset_n5  (hreset_n5),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .done       (done),
    .rdata_mux  (rdata_mux),
    .accept     (accept),
    .addr_q     (addr_q),
    .write_q    (write_q),
    .data_phase (data_phase),
    .hready     (hready),
    .hrdata     (hrdata)
  );

  apb_addr_decode #(
    .NUM_SLAVES  (NUM_SLAVES),
    .SLAVE_START (SLAVE_START),
    .SLAVE_END   (SLAVE_END)
  ) u_apb_addr_decode (
    .hclk5     (hclk5),
    .hreset_n5 (hreset_n5),
    .accept    (accept),
    .haddr     (haddr),
    .sel_q     (sel_q)
  );

  apb_master_fsm #(
    .NUM_SLAVES (NUM_SLAVES)
  ) u_apb_master_fsm (
    .hclk5      (hclk5),
    .hreset_n5  (hreset_n5),
    .data_phase (data_phase),
    .sel_q      (sel_q),
    .addr_q     (addr_q),
    .write_q    (write_q),
    .pready     (pready),
    .prdata     (prdata),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .done       (done),
    .rdata_mux  (rdata_mux)
  );

endmodule

`default_nettype wire

/* source/apb_master_fsm.sv */
// APB master state machine, APB address/control outputs and pready/prdata return mux
`timescale 1ns/1ps
`default_nettype none

module apb_master_fsm #(
  parameter int NUM_SLAVES = 4
) (
  input  wire logic                   hclk5,
  input  wire logic                   hreset_n5,
  input  wire logic                   data_phase,
  input  wire logic [NUM_SLAVES-1:0]  sel_q,
  input  wire ahb_apb_pkg::addr_t     addr_q,
  input  wire logic                   write_q,
  input  wire logic [NUM_SLAVES-1:0]  pready,
  input  wire ahb_apb_pkg::data_t     prdata [NUM_SLAVES],
  output logic [NUM_SLAVES-1:0]       psel,
  output logic                        penable,
  output ahb_apb_pkg::addr_t          paddr,
  output logic                        pwrite,
  output logic                        done,
  output ahb_apb_pkg::data_t          rdata_mux
);

  import ahb_apb_pkg::*;

  apb_state_e state;
  logic       pready_mux;

  // ------------------------------------------------------------------------
  // Return path from the selected slave
  // ------------------------------------------------------------------------
  assign pready_mux = |(psel & pready);

  // AND-OR mux, unselected slaves contribute zero
  always_comb begin
    rdata_mux = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (psel[i]) begin
        rdata_mux = rdata_mux | prdata[i];
      end
    end
  end

  // No slave selected means nobody can stall, so finish straight away
  assign done = (state == APB_ACCESS) && (pready_mux || (psel == '0));

  // ------------------------------------------------------------------------
  // IDLE -> SETUP -> ACCESS -> IDLE
  // ------------------------------------------------------------------------
  always_ff @(posedge hclk5 or negedge hreset_n5) begin
    if (!hreset_n5) begin
      state   <= APB_IDLE;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          if (data_phase) begin
            state  <= APB_SETUP;
            psel   <= sel_q;
            paddr  <= addr_q;
            pwrite <= write_q;
          end
        end

        APB_SETUP: begin
          state   <= APB_ACCESS;
          penable <= 1'b1;
        end

        APB_ACCESS: begin
          // Hold here while the slave inserts wait states
          if (done) begin
            state   <= APB_IDLE;
            psel    <= '0;
            penable <= 1'b0;
          end
        end

        default: begin
          state   <= APB_IDLE;
          psel    <= '0;
          penable <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/apb_addr_decode.sv */
// Inclusive range decode of the AHB address into a registered one-hot APB select
`timescale 1ns/1ps
`default_nettype none

module apb_addr_decode #(
  parameter int                 NUM_SLAVES = 4,
  parameter ahb_apb_pkg::addr_t SLAVE_START [NUM_SLAVES] = '{default: '0},
  parameter ahb_apb_pkg::addr_t SLAVE_END   [NUM_SLAVES] = '{default: '0}
) (
  input  wire logic                   hclk5,
  input  wire logic                   hreset_n5,
  input  wire logic                   accept,
  input  wire ahb_apb_pkg::addr_t     haddr,
  output logic [NUM_SLAVES-1:0]       sel_q
);

  logic [NUM_SLAVES-1:0] hit;

  // ------------------------------------------------------------------------
  // Range compare, one comparator pair per slave
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_range
    assign hit[i] = (haddr >= SLAVE_START[i]) && (haddr <= SLAVE_END[i]);
  end

  // Held for the whole transfer; an unmapped address leaves all bits low
  always_ff @(posedge hclk5 or negedge hreset_n5) begin
    if (!hreset_n5) begin
      sel_q <= '0;
    end else if (accept) begin
      sel_q <= hit;
    end
  end

endmodule

`default_nettype wire

/* source/ahb_front.sv */
// AHB slave front end: transfer qualification, phase flags, address capture, read return
`timescale 1ns/1ps
`default_nettype none

module ahb_front (
  input  wire logic                hclk5,
  input  wire logic                hreset_n5,
  input  wire logic                hsel,
  input  wire ahb_apb_pkg::addr_t  haddr,
  input  wire ahb_apb_pkg::htrans_e htrans,
  input  wire logic                hwrite,
  input  wire logic                done,
  input  wire ahb_apb_pkg::data_t  rdata_mux,
  output logic                     accept,
  output ahb_apb_pkg::addr_t       addr_q,
  output logic                     write_q,
  output logic                     data_phase,
  output logic                     hready,
  output ahb_apb_pkg::data_t       hrdata
);

  import ahb_apb_pkg::*;

  logic addr_phase;
  logic valid_trans;

  // Only NONSEQ and SEQ carry a transfer; IDLE and BUSY are ignored
  assign valid_trans = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // Address taken only while the bridge is free
  assign accept = valid_trans && addr_phase;

  // Wait states inserted from acceptance until APB completion
  assign hready = addr_phase;

  // ------------------------------------------------------------------------
  // Phase flags and captured transfer
  // ------------------------------------------------------------------------
  always_ff @(posedge hclk5 or negedge hreset_n5) begin
    if (!hreset_n5) begin
      addr_phase <= 1'b1;
      data_phase <= 1'b0;
      addr_q     <= '0;
      write_q    <= 1'b0;
      hrdata     <= '0;
    end else begin
      if (accept) begin
        addr_phase <= 1'b0;
        data_phase <= 1'b1;
        addr_q     <= haddr;
        write_q    <= hwrite;
      end
      // Completion never coincides with accept, hready is low then
      if (done) begin
        addr_phase <= 1'b1;
        data_phase <= 1'b0;
        hrdata     <= rdata_mux;
      end
    end
  end

endmodule

`default_nettype wire

/* source/ahb_apb_pkg.sv */
// Shared bus widths, address/data vector types, AHB transfer and APB state encodings
`default_nettype none

package ahb_apb_pkg;

  // ------------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // AHB htrans encoding
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // APB master phases
  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,
    APB_ACCESS = 2'b10
  } apb_state_e;

endpackage

`default_nettype wire
